//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_top -f tb.f -o sim_tb_top

if ./obj_dir/sim_tb_top | tee /dev/stderr | grep -q 'All tests passed!'; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

//--- src/mem_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter import mem_pkg::*; (
    input  wire                clk,
    input  wire                rst,

    // Fetch read port
    input  wire                if_ar_valid_i,
    output logic               if_ar_ready_o,
    input  wire  [ADDR_W-1:0]  if_ar_addr_i,
    output logic               if_r_valid_o,
    input  wire                if_r_ready_i,
    output logic [DATA_W-1:0]  if_r_data_o,
    output resp_e              if_r_resp_o,

    // Load/store read port
    input  wire                ls_ar_valid_i,
    output logic               ls_ar_ready_o,
    input  wire  [ADDR_W-1:0]  ls_ar_addr_i,
    output logic               ls_r_valid_o,
    input  wire                ls_r_ready_i,
    output logic [DATA_W-1:0]  ls_r_data_o,
    output resp_e              ls_r_resp_o,

    // Load/store write port
    input  wire                ls_aw_valid_i,
    output logic               ls_aw_ready_o,
    input  wire  [ADDR_W-1:0]  ls_aw_addr_i,
    input  wire                ls_w_valid_i,
    output logic               ls_w_ready_o,
    input  wire  [DATA_W-1:0]  ls_w_data_i,
    input  wire  [STRB_W-1:0]  ls_w_strb_i,
    output logic               ls_b_valid_o,
    input  wire                ls_b_ready_i,
    output resp_e              ls_b_resp_o,

    // To the SRAM
    output logic               mem_ar_valid_o,
    input  wire                mem_ar_ready_i,
    output logic [ADDR_W-1:0]  mem_ar_addr_o,
    input  wire                mem_r_valid_i,
    output logic               mem_r_ready_o,
    input  wire  [DATA_W-1:0]  mem_r_data_i,
    input  resp_e              mem_r_resp_i,
    output logic               mem_aw_valid_o,
    input  wire                mem_aw_ready_i,
    output logic [ADDR_W-1:0]  mem_aw_addr_o,
    output logic               mem_w_valid_o,
    input  wire                mem_w_ready_i,
    output logic [DATA_W-1:0]  mem_w_data_o,
    output logic [STRB_W-1:0]  mem_w_strb_o,
    input  wire                mem_b_valid_i,
    output logic               mem_b_ready_o,
    input  resp_e              mem_b_resp_i
);

    rd_grant_e rd_state_q;
    rd_grant_e rd_state_d;
    logic      sel_ls;
    logic      if_r_hs;
    logic      ls_r_hs;

    // Fetch owns the read path in RD_IDLE and RD_FETCH
    assign sel_ls  = (rd_state_q == RD_LSU);
    assign if_r_hs = if_r_valid_o && if_r_ready_i;
    assign ls_r_hs = ls_r_valid_o && ls_r_ready_i;

    always_comb begin
        rd_state_d = rd_state_q;
        case (rd_state_q)
            RD_IDLE: begin
                if (if_ar_valid_i && mem_ar_ready_i) begin
                    rd_state_d = RD_FETCH;
                end else if (ls_ar_valid_i && !if_ar_valid_i) begin
                    rd_state_d = RD_LSU;
                end
            end
            RD_FETCH: begin
                if (if_r_hs) begin
                    rd_state_d = RD_IDLE;
                end
            end
            RD_LSU: begin
                if (ls_r_hs) begin
                    rd_state_d = RD_IDLE;
                end
            end
            default: begin
                rd_state_d = RD_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state_q <= RD_IDLE;
        end else begin
            rd_state_q <= rd_state_d;
        end
    end

    // Read address mux
    assign mem_ar_valid_o = sel_ls ? ls_ar_valid_i : if_ar_valid_i;
    assign mem_ar_addr_o  = sel_ls ? ls_ar_addr_i  : if_ar_addr_i;
    assign if_ar_ready_o  = sel_ls ? 1'b0 : mem_ar_ready_i;
    assign ls_ar_ready_o  = sel_ls ? mem_ar_ready_i : 1'b0;

    // Idle side of the read data steering sees zeros
    assign mem_r_ready_o = sel_ls ? ls_r_ready_i : if_r_ready_i;
    assign if_r_valid_o  = sel_ls ? 1'b0 : mem_r_valid_i;
    assign if_r_data_o   = sel_ls ? '0 : mem_r_data_i;
    assign if_r_resp_o   = sel_ls ? RESP_OKAY : mem_r_resp_i;
    assign ls_r_valid_o  = sel_ls ? mem_r_valid_i : 1'b0;
    assign ls_r_data_o   = sel_ls ? mem_r_data_i : '0;
    assign ls_r_resp_o   = sel_ls ? mem_r_resp_i : RESP_OKAY;

    // Writes come only from load/store
    assign mem_aw_valid_o = ls_aw_valid_i;
    assign mem_aw_addr_o  = ls_aw_addr_i;
    assign ls_aw_ready_o  = mem_aw_ready_i;
    assign mem_w_valid_o  = ls_w_valid_i;
    assign mem_w_data_o   = ls_w_data_i;
    assign mem_w_strb_o   = ls_w_strb_i;
    assign ls_w_ready_o   = mem_w_ready_i;
    assign ls_b_valid_o   = mem_b_valid_i;
    assign ls_b_resp_o    = mem_b_resp_i;
    assign mem_b_ready_o  = ls_b_ready_i;

    // SRAM read responses only arrive while one port holds the grant
    r_granted_a: assert property (@(posedge clk) disable iff (rst)
        mem_r_valid_i |-> (rd_state_q != RD_IDLE))
        else $error("read response with no port granted");

    // Load/store grant only drops after its own r transfer
    ls_grant_hold_a: assert property (@(posedge clk) disable iff (rst)
        (rd_state_q == RD_LSU) && !ls_r_hs |=> (rd_state_q == RD_LSU))
        else $error("load/store grant released without r transfer");

    // Fetch response never lands outside its grant
    if_r_owner_a: assert property (@(posedge clk) disable iff (rst)
        if_r_valid_o |-> (rd_state_q == RD_FETCH))
        else $error("fetch r_valid outside fetch grant");

endmodule

`default_nettype wire

//--- src/mem_pkg.sv
`default_nettype none

package mem_pkg;

    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 64;
    localparam int STRB_W    = 8;
    localparam int MEM_WORDS = 256;

    // Word index and byte offset widths inside a byte address
    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam int OFS_W = $clog2(STRB_W);

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2
    } resp_e;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_FETCH,
        RD_LSU
    } rd_grant_e;

    typedef enum logic {
        SR_IDLE,
        SR_RESP
    } sram_rd_e;

    typedef enum logic {
        SW_IDLE,
        SW_RESP
    } sram_wr_e;

endpackage

`default_nettype wire

//--- src/mem_sram.sv
`timescale 1ns/100ps
`default_nettype none

module mem_sram import mem_pkg::*; (
    input  wire                clk,
    input  wire                rst,

    input  wire                ar_valid_i,
    output logic               ar_ready_o,
    input  wire  [ADDR_W-1:0]  ar_addr_i,
    output logic               r_valid_o,
    input  wire                r_ready_i,
    output logic [DATA_W-1:0]  r_data_o,
    output resp_e              r_resp_o,

    input  wire                aw_valid_i,
    output logic               aw_ready_o,
    input  wire  [ADDR_W-1:0]  aw_addr_i,
    input  wire                w_valid_i,
    output logic               w_ready_o,
    input  wire  [DATA_W-1:0]  w_data_i,
    input  wire  [STRB_W-1:0]  w_strb_i,
    output logic               b_valid_o,
    input  wire                b_ready_i,
    output resp_e              b_resp_o
);

    logic [DATA_W-1:0] mem_q [MEM_WORDS];

    sram_rd_e          rd_state_q;
    sram_wr_e          wr_state_q;
    logic [DATA_W-1:0] r_data_q;
    resp_e             r_resp_q;
    resp_e             b_resp_q;
    logic              ar_hs;
    logic              wr_hs;
    logic              ar_in_range;
    logic              aw_in_range;
    logic [IDX_W-1:0]  ar_idx;
    logic [IDX_W-1:0]  aw_idx;

    // Anything above the word index bits must be zero
    assign ar_in_range = (ar_addr_i[ADDR_W-1:IDX_W+OFS_W] == '0);
    assign aw_in_range = (aw_addr_i[ADDR_W-1:IDX_W+OFS_W] == '0);
    assign ar_idx      = ar_addr_i[IDX_W+OFS_W-1:OFS_W];
    assign aw_idx      = aw_addr_i[IDX_W+OFS_W-1:OFS_W];

    // Read side
    assign ar_ready_o = (rd_state_q == SR_IDLE);
    assign ar_hs      = ar_valid_i && ar_ready_o;
    assign r_valid_o  = (rd_state_q == SR_RESP);
    assign r_data_o   = r_data_q;
    assign r_resp_o   = r_resp_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state_q <= SR_IDLE;
        end else begin
            case (rd_state_q)
                SR_IDLE: begin
                    if (ar_hs) begin
                        rd_state_q <= SR_RESP;
                    end
                end
                SR_RESP: begin
                    if (r_ready_i) begin
                        rd_state_q <= SR_IDLE;
                    end
                end
                default: begin
                    rd_state_q <= SR_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            if (ar_in_range) begin
                r_data_q <= mem_q[ar_idx];
                r_resp_q <= RESP_OKAY;
            end else begin
                r_data_q <= '0;
                r_resp_q <= RESP_SLVERR;
            end
        end
    end

    // Write side takes address and data in the same cycle
    assign wr_hs      = (wr_state_q == SW_IDLE) && aw_valid_i && w_valid_i;
    assign aw_ready_o = wr_hs;
    assign w_ready_o  = wr_hs;
    assign b_valid_o  = (wr_state_q == SW_RESP);
    assign b_resp_o   = b_resp_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state_q <= SW_IDLE;
        end else if (wr_state_q == SW_IDLE) begin
            if (wr_hs) begin
                wr_state_q <= SW_RESP;
            end
        end else if (b_ready_i) begin
            wr_state_q <= SW_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            if (aw_in_range) begin
                b_resp_q <= RESP_OKAY;
            end else begin
                b_resp_q <= RESP_SLVERR;
            end
        end
    end

    // Byte lanes with strobe set
    always_ff @(posedge clk) begin
        if (wr_hs && aw_in_range) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (w_strb_i[b]) begin
                    mem_q[aw_idx][b*8 +: 8] <= w_data_i[b*8 +: 8];
                end
            end
        end
    end

    r_hold_a: assert property (@(posedge clk) disable iff (rst)
        r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o) && $stable(r_resp_o))
        else $error("read response dropped before r_ready");

    b_hold_a: assert property (@(posedge clk) disable iff (rst)
        b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_resp_o))
        else $error("write response dropped before b_ready");

endmodule

`default_nettype wire

//--- src/mem_subsystem_top.sv
`timescale 1ns/100ps
`default_nettype none

module mem_subsystem_top import mem_pkg::*; (
    input  wire                clk,
    input  wire                rst,

    input  wire                if_ar_valid_i,
    output logic               if_ar_ready_o,
    input  wire  [ADDR_W-1:0]  if_ar_addr_i,
    output logic               if_r_valid_o,
    input  wire                if_r_ready_i,
    output logic [DATA_W-1:0]  if_r_data_o,
    output resp_e              if_r_resp_o,

    input  wire                ls_ar_valid_i,
    output logic               ls_ar_ready_o,
    input  wire  [ADDR_W-1:0]  ls_ar_addr_i,
    output logic               ls_r_valid_o,
    input  wire                ls_r_ready_i,
    output logic [DATA_W-1:0]  ls_r_data_o,
    output resp_e              ls_r_resp_o,

    input  wire                ls_aw_valid_i,
    output logic               ls_aw_ready_o,
    input  wire  [ADDR_W-1:0]  ls_aw_addr_i,
    input  wire                ls_w_valid_i,
    output logic               ls_w_ready_o,
    input  wire  [DATA_W-1:0]  ls_w_data_i,
    input  wire  [STRB_W-1:0]  ls_w_strb_i,
    output logic               ls_b_valid_o,
    input  wire                ls_b_ready_i,
    output resp_e              ls_b_resp_o
);

    // Arbiter to SRAM
    logic              mem_ar_valid;
    logic              mem_ar_ready;
    logic [ADDR_W-1:0] mem_ar_addr;
    logic              mem_r_valid;
    logic              mem_r_ready;
    logic [DATA_W-1:0] mem_r_data;
    resp_e             mem_r_resp;
    logic              mem_aw_valid;
    logic              mem_aw_ready;
    logic [ADDR_W-1:0] mem_aw_addr;
    logic              mem_w_valid;
    logic              mem_w_ready;
    logic [DATA_W-1:0] mem_w_data;
    logic [STRB_W-1:0] mem_w_strb;
    logic              mem_b_valid;
    logic              mem_b_ready;
    resp_e             mem_b_resp;

    mem_arbiter u_arbiter (
        .clk            (clk),
        .rst            (rst),
        .if_ar_valid_i  (if_ar_valid_i),
        .if_ar_ready_o  (if_ar_ready_o),
        .if_ar_addr_i   (if_ar_addr_i),
        .if_r_valid_o   (if_r_valid_o),
        .if_r_ready_i   (if_r_ready_i),
        .if_r_data_o    (if_r_data_o),
        .if_r_resp_o    (if_r_resp_o),
        .ls_ar_valid_i  (ls_ar_valid_i),
        .ls_ar_ready_o  (ls_ar_ready_o),
        .ls_ar_addr_i   (ls_ar_addr_i),
        .ls_r_valid_o   (ls_r_valid_o),
        .ls_r_ready_i   (ls_r_ready_i),
        .ls_r_data_o    (ls_r_data_o),
        .ls_r_resp_o    (ls_r_resp_o),
        .ls_aw_valid_i  (ls_aw_valid_i),
        .ls_aw_ready_o  (ls_aw_ready_o),
        .ls_aw_addr_i   (ls_aw_addr_i),
        .ls_w_valid_i   (ls_w_valid_i),
        .ls_w_ready_o   (ls_w_ready_o),
        .ls_w_data_i    (ls_w_data_i),
        .ls_w_strb_i    (ls_w_strb_i),
        .ls_b_valid_o   (ls_b_valid_o),
        .ls_b_ready_i   (ls_b_ready_i),
        .ls_b_resp_o    (ls_b_resp_o),
        .mem_ar_valid_o (mem_ar_valid),
        .mem_ar_ready_i (mem_ar_ready),
        .mem_ar_addr_o  (mem_ar_addr),
        .mem_r_valid_i  (mem_r_valid),
        .mem_r_ready_o  (mem_r_ready),
        .mem_r_data_i   (mem_r_data),
        .mem_r_resp_i   (mem_r_resp),
        .mem_aw_valid_o (mem_aw_valid),
        .mem_aw_ready_i (mem_aw_ready),
        .mem_aw_addr_o  (mem_aw_addr),
        .mem_w_valid_o  (mem_w_valid),
        .mem_w_ready_i  (mem_w_ready),
        .mem_w_data_o   (mem_w_data),
        .mem_w_strb_o   (mem_w_strb),
        .mem_b_valid_i  (mem_b_valid),
        .mem_b_ready_o  (mem_b_ready),
        .mem_b_resp_i   (mem_b_resp)
    );

    mem_sram u_sram (
        .clk        (clk),
        .rst        (rst),
        .ar_valid_i (mem_ar_valid),
        .ar_ready_o (mem_ar_ready),
        .ar_addr_i  (mem_ar_addr),
        .r_valid_o  (mem_r_valid),
        .r_ready_i  (mem_r_ready),
        .r_data_o   (mem_r_data),
        .r_resp_o   (mem_r_resp),
        .aw_valid_i (mem_aw_valid),
        .aw_ready_o (mem_aw_ready),
        .aw_addr_i  (mem_aw_addr),
        .w_valid_i  (mem_w_valid),
        .w_ready_o  (mem_w_ready),
        .w_data_i   (mem_w_data),
        .w_strb_i   (mem_w_strb),
        .b_valid_o  (mem_b_valid),
        .b_ready_i  (mem_b_ready),
        .b_resp_o   (mem_b_resp)
    );

endmodule

`default_nettype wire

//--- tb.f
src/mem_pkg.sv
src/mem_arbiter.sv
src/mem_sram.sv
src/mem_subsystem_top.sv
tests/tb_top.sv

//--- tests/tb_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_top import mem_pkg::*; ();

    localparam int PERIOD    = 8;
    localparam int N_IF      = 400;
    localparam int N_LS      = 400;
    localparam int CYC_BOUND = 40;
    localparam int LIMIT_NS  = (MEM_WORDS + N_IF + N_LS + 20) * CYC_BOUND * PERIOD;

    logic clk;
    logic rst;
    logic if_ar_valid_i, if_ar_ready_o, if_r_valid_o, if_r_ready_i;
    logic [ADDR_W-1:0] if_ar_addr_i;
    logic [DATA_W-1:0] if_r_data_o;
    resp_e if_r_resp_o;
    logic ls_ar_valid_i, ls_ar_ready_o, ls_r_valid_o, ls_r_ready_i;
    logic [ADDR_W-1:0] ls_ar_addr_i;
    logic [DATA_W-1:0] ls_r_data_o;
    resp_e ls_r_resp_o;
    logic ls_aw_valid_i, ls_aw_ready_o, ls_w_valid_i, ls_w_ready_o;
    logic ls_b_valid_o, ls_b_ready_i;
    logic [ADDR_W-1:0] ls_aw_addr_i;
    logic [DATA_W-1:0] ls_w_data_i;
    logic [STRB_W-1:0] ls_w_strb_i;
    resp_e ls_b_resp_o;

    logic [DATA_W-1:0] model [MEM_WORDS];
    logic [31:0] seed;
    int cyc, phase, wr_idx, if_left, ls_left;
    int if_raise_cyc, if_ar_cyc, ls_raise_cyc, ls_ar_cyc;
    bit if_ar_pend, if_r_pend, if_prompt, contend;
    bit ls_ar_pend, ls_r_pend, ls_wr_pend, ls_b_pend, ls_lone;
    logic [ADDR_W-1:0] if_rd_addr, ls_rd_addr;
    logic [DATA_W-1:0] if_exp_data, ls_exp_data;
    resp_e if_exp_resp, ls_exp_resp, ls_exp_b;

    mem_subsystem_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(LIMIT_NS);
        stop_on_error("Timeout: the watchdog expired before all transactions completed");
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return {seed[15:0], seed[31:16]};
    endfunction

    // Anything from MEM_WORDS*8 bytes up is outside the SRAM
    function automatic logic addr_ok(input logic [ADDR_W-1:0] a);
        return a < 32'(MEM_WORDS * 8);
    endfunction

    function automatic logic [DATA_W-1:0] read_expect(input logic [ADDR_W-1:0] a);
        return addr_ok(a) ? model[IDX_W'(a >> 3)] : '0;
    endfunction

    function automatic resp_e resp_expect(input logic [ADDR_W-1:0] a);
        return addr_ok(a) ? RESP_OKAY : RESP_SLVERR;
    endfunction

    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old,
            input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] res;
        res = old;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) res[b*8 +: 8] = data[b*8 +: 8];
        end
        return res;
    endfunction

    function automatic bit busy();
        return if_ar_pend || if_r_pend || ls_ar_pend || ls_r_pend || ls_wr_pend || ls_b_pend;
    endfunction

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_quiet();
        assert (!if_r_valid_o && !ls_r_valid_o && !ls_b_valid_o)
            else stop_on_error($sformatf("[FAIL] t=%0t response valid high around reset", $time));
    endtask

    task automatic run_cycle();
        logic [31:0] r;
        bit reads_idle, new_if, new_ls_rd;
        @(negedge clk);
        cyc++;
        r = next_rand();
        if_ar_valid_i = if_ar_pend;
        ls_ar_valid_i = ls_ar_pend;
        ls_aw_valid_i = ls_wr_pend;
        ls_w_valid_i  = ls_wr_pend;
        // Random back-pressure on the response channels
        if_r_ready_i = (r[1:0] != 2'd0);
        ls_r_ready_i = (r[3:2] != 2'd0);
        ls_b_ready_i = (r[5:4] != 2'd0);
        reads_idle = !if_ar_pend && !if_r_pend && !ls_ar_pend && !ls_r_pend;
        new_if = 1'b0;
        new_ls_rd = 1'b0;
        if (!if_ar_pend && !if_r_pend && if_left > 0 && r[6]) begin
            if_ar_addr_i  = {21'd0, 1'b0, r[14:8], r[18:16]};
            if_ar_valid_i = 1'b1;
            if_ar_pend    = 1'b1;
            if_raise_cyc  = cyc;
            if_left--;
            new_if = 1'b1;
        end
        if (!busy_ls() && ls_left > 0 && r[7]) begin
            ls_left--;
            if (phase == 1) begin
                ls_aw_addr_i = ADDR_W'(wr_idx) << 3;
                ls_w_strb_i  = '1;
                wr_idx++;
            end else if (r[22:20] == 3'd0) begin
                ls_aw_addr_i = {r[31:11] | 21'd1, r[10:0]};
                ls_w_strb_i  = STRB_W'(next_rand());
            end else begin
                ls_aw_addr_i = {21'd0, 1'b1, r[29:23], r[18:16]};
                ls_w_strb_i  = STRB_W'(next_rand());
            end
            if (phase == 2 && r[19]) begin
                ls_ar_addr_i  = ls_aw_addr_i;
                ls_ar_valid_i = 1'b1;
                ls_ar_pend    = 1'b1;
                ls_raise_cyc  = cyc;
                new_ls_rd     = 1'b1;
            end else begin
                ls_w_data_i   = {next_rand(), next_rand()};
                ls_aw_valid_i = 1'b1;
                ls_w_valid_i  = 1'b1;
                ls_wr_pend    = 1'b1;
            end
        end
        if (new_if) if_prompt = reads_idle;
        if (new_ls_rd) ls_lone = reads_idle && !new_if;
        if (reads_idle && new_if && new_ls_rd) contend = 1'b1;
        #1;
        assert (!(if_r_valid_o && ls_r_valid_o))
            else stop_on_error($sformatf("[FAIL] t=%0t r_valid on both ports", $time));
        assert ((!if_r_valid_o || if_r_pend) && (!ls_r_valid_o || ls_r_pend))
            else stop_on_error($sformatf("[FAIL] t=%0t r_valid on a port with no read", $time));
        assert (!ls_b_valid_o || ls_b_pend)
            else stop_on_error($sformatf("[FAIL] t=%0t b_valid with no write", $time));
        if (if_ar_pend && if_prompt && cyc == if_raise_cyc)
            assert (if_ar_ready_o)
                else stop_on_error($sformatf("[FAIL] t=%0t idle fetch not accepted", $time));
        if (ls_ar_pend && ls_lone && cyc == ls_raise_cyc + 1)
            assert (ls_ar_ready_o)
                else stop_on_error($sformatf("[FAIL] t=%0t lone load/store ar late", $time));
        if (if_r_pend && cyc == if_ar_cyc + 1)
            assert (if_r_valid_o)
                else stop_on_error($sformatf("[FAIL] t=%0t fetch r_valid late", $time));
        if (ls_r_pend && cyc == ls_ar_cyc + 1)
            assert (ls_r_valid_o)
                else stop_on_error($sformatf("[FAIL] t=%0t load/store r_valid late", $time));

        // Reads sample the model before a write on the same edge
        if (if_ar_valid_i && if_ar_ready_o) begin
            if_rd_addr  = if_ar_addr_i;
            if_exp_data = read_expect(if_ar_addr_i);
            if_exp_resp = resp_expect(if_ar_addr_i);
            if_ar_pend  = 1'b0;
            if_r_pend   = 1'b1;
            if_ar_cyc   = cyc;
        end
        if (ls_ar_valid_i && ls_ar_ready_o) begin
            assert (!contend)
                else stop_on_error($sformatf("[FAIL] t=%0t load/store ar before fetch r", $time));
            ls_rd_addr  = ls_ar_addr_i;
            ls_exp_data = read_expect(ls_ar_addr_i);
            ls_exp_resp = resp_expect(ls_ar_addr_i);
            ls_ar_pend  = 1'b0;
            ls_r_pend   = 1'b1;
            ls_ar_cyc   = cyc;
        end
        if (if_r_valid_o && if_r_ready_i) begin
            assert (if_r_data_o == if_exp_data && if_r_resp_o == if_exp_resp)
                else stop_on_error($sformatf("[FAIL] t=%0t fetch %h got %h/%0d expected %h/%0d",
                    $time, if_rd_addr, if_r_data_o, if_r_resp_o, if_exp_data, if_exp_resp));
            if_r_pend = 1'b0;
            contend   = 1'b0;
        end
        if (ls_r_valid_o && ls_r_ready_i) begin
            assert (ls_r_data_o == ls_exp_data && ls_r_resp_o == ls_exp_resp)
                else stop_on_error($sformatf("[FAIL] t=%0t load %h got %h/%0d expected %h/%0d",
                    $time, ls_rd_addr, ls_r_data_o, ls_r_resp_o, ls_exp_data, ls_exp_resp));
            ls_r_pend = 1'b0;
        end
        if (ls_aw_valid_i && ls_aw_ready_o) begin
            assert (ls_w_ready_o)
                else stop_on_error($sformatf("[FAIL] t=%0t aw taken without w", $time));
            ls_exp_b = resp_expect(ls_aw_addr_i);
            if (addr_ok(ls_aw_addr_i)) begin
                model[IDX_W'(ls_aw_addr_i >> 3)] =
                    merge_bytes(model[IDX_W'(ls_aw_addr_i >> 3)], ls_w_data_i, ls_w_strb_i);
            end
            ls_wr_pend = 1'b0;
            ls_b_pend  = 1'b1;
        end
        if (ls_b_valid_o && ls_b_ready_i) begin
            assert (ls_b_resp_o == ls_exp_b)
                else stop_on_error($sformatf("[FAIL] t=%0t store %h b_resp %0d expected %0d",
                    $time, ls_aw_addr_i, ls_b_resp_o, ls_exp_b));
            ls_b_pend = 1'b0;
        end
    endtask

    function automatic bit busy_ls();
        return ls_ar_pend || ls_r_pend || ls_wr_pend || ls_b_pend;
    endfunction

    initial begin
        seed = 32'd60;
        rst = 1'b1;
        {if_ar_valid_i, if_r_ready_i, ls_ar_valid_i, ls_r_ready_i} = '0;
        {ls_aw_valid_i, ls_w_valid_i, ls_b_ready_i} = '0;
        if_ar_addr_i = '0;
        ls_ar_addr_i = '0;
        ls_aw_addr_i = '0;
        ls_w_data_i  = '0;
        ls_w_strb_i  = '0;
        for (int i = 0; i < MEM_WORDS; i++) model[i] = '0;
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #1;
            check_quiet();
        end
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        #1;
        check_quiet();

        // Fill the whole memory through the load/store port
        phase   = 1;
        ls_left = MEM_WORDS;
        while (ls_left > 0 || busy()) run_cycle();

        phase   = 2;
        if_left = N_IF;
        ls_left = N_LS;
        while (if_left > 0 || ls_left > 0 || busy()) run_cycle();

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire
